//--- rvDecodePkg.sv
package rvDecodePkg;

    localparam int InstWidth    = 32;
    localparam int Funct3Width  = 3;
    localparam int Funct7Width  = 7;
    localparam int Funct12Width = 12;
    localparam int MaskWidth    = 8;

    localparam logic [Funct7Width-1:0]  Funct7Alt     = 7'b0100000; // sub / sra variant
    localparam logic [Funct12Width-1:0] Funct12Ecall  = 12'h000;
    localparam logic [Funct12Width-1:0] Funct12Ebreak = 12'h001;
    localparam logic [Funct12Width-1:0] Funct12Mret   = 12'h302;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpBranch = 7'b1100011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpImm    = 7'b0010011,
        OpReg    = 7'b0110011,
        OpSystem = 7'b1110011
    } opcodeE;

    typedef enum logic [2:0] {
        TypeI = 3'd0, TypeS = 3'd1, TypeR = 3'd2, TypeU = 3'd3,
        TypeJ = 3'd4, TypeB = 3'd5, TypeN = 3'd6
    } instTypeE;

    typedef enum logic [2:0] {
        MemByte = 3'd0, MemHalf = 3'd1, MemWord = 3'd2, MemByteU = 3'd3, MemHalfU = 3'd4
    } memTypeE;

    typedef enum logic [2:0] {
        CmpEq = 3'd0, CmpNe = 3'd1, CmpLt = 3'd2, CmpGe = 3'd3, CmpLtu = 3'd4, CmpGeu = 3'd5
    } cmpTypeE;

    typedef enum logic [2:0] {
        AluAdd = 3'd0, AluSub = 3'd1, AluSra = 3'd2, AluAnd = 3'd3,
        AluOr  = 3'd4, AluXor = 3'd5, AluSll = 3'd6, AluSrl = 3'd7
    } aluOpE;

    typedef enum logic [2:0] {
        RdAlu = 3'd0, RdMem = 3'd1, RdSnpc = 3'd2, RdCmp = 3'd3, RdCsr = 3'd4, RdNone = 3'd5
    } rdSrcE;

    typedef enum logic [1:0] {
        Src1Reg = 2'd0, Src1Pc = 2'd1, Src1Zero = 2'd2
    } aluSrc1E;

    typedef enum logic [1:0] {
        Src2Reg = 2'd0, Src2Imm = 2'd1, Src2Csr = 2'd2
    } aluSrc2E;

    // full decode result, one per instruction
    typedef struct packed {
        logic                 memValid;
        logic [MaskWidth-1:0] memWmask;
        logic                 memWen;
        memTypeE              memType;
        cmpTypeE              cmpType;
        logic                 branch;
        logic                 jump;
        logic                 jalr;
        aluOpE                aluOp;
        rdSrcE                rdSrc;
        aluSrc1E              aluSrc1;
        aluSrc2E              aluSrc2;
        instTypeE             instType;
        logic                 ecall;
        logic                 mret;
        logic                 writeCsr;
        logic                 stopSim;  // ebreak or illegal opcode
    } ctrlWordT;

endpackage

//--- classIf.sv
interface classIf;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;      // funct3 must be 000
    logic branch;
    logic load;
    logic store;
    logic immArith;
    logic regArith;
    logic ebreak;
    logic ecall;
    logic mret;
    logic csrOp;     // any system opcode
    logic mismatch;  // nothing above matched

    modport source (
        output lui, auipc, jal, jalr, branch, load, store, immArith, regArith,
               ebreak, ecall, mret, csrOp, mismatch
    );

    modport sink (
        input lui, auipc, jal, jalr, branch, load, store, immArith, regArith,
              ebreak, ecall, mret, csrOp, mismatch
    );
endinterface

//--- funcIf.sv
interface funcIf;
    import rvDecodePkg::*;

    aluOpE                regAluOp;   // op form
    aluOpE                immAluOp;   // op-imm form, no sub
    cmpTypeE              branchCmp;
    cmpTypeE              setCmp;     // slt / sltu
    logic                 isSetForm;
    logic [MaskWidth-1:0] memMask;
    memTypeE              memType;

    modport source (
        output regAluOp, immAluOp, branchCmp, setCmp, isSetForm, memMask, memType
    );

    modport sink (
        input regAluOp, immAluOp, branchCmp, setCmp, isSetForm, memMask, memType
    );
endinterface

//--- opClassDecode.sv
module opClassDecode (
    input  logic [6:0]                            opcode,
    input  logic [rvDecodePkg::Funct3Width-1:0]   funct3,
    input  logic [rvDecodePkg::Funct12Width-1:0]  funct12,
    classIf.source                                cls
);
    import rvDecodePkg::*;

    logic sysZero;  // system opcode with funct3 000

    assign sysZero = (opcode == OpSystem) && (funct3 == 3'b000);

    assign cls.lui      = opcode == OpLui;
    assign cls.auipc    = opcode == OpAuipc;
    assign cls.jal      = opcode == OpJal;
    assign cls.jalr     = (opcode == OpJalr) && (funct3 == 3'b000); // other funct3 is illegal
    assign cls.branch   = opcode == OpBranch;
    assign cls.load     = opcode == OpLoad;
    assign cls.store    = opcode == OpStore;
    assign cls.immArith = opcode == OpImm;
    assign cls.regArith = opcode == OpReg;

    // system sub-codes, all of them also raise csrOp
    assign cls.ecall  = sysZero && (funct12 == Funct12Ecall);
    assign cls.ebreak = sysZero && (funct12 == Funct12Ebreak);
    assign cls.mret   = sysZero && (funct12 == Funct12Mret);
    assign cls.csrOp  = opcode == OpSystem;

    assign cls.mismatch = ~(cls.lui | cls.auipc | cls.jal | cls.jalr | cls.branch
                          | cls.load | cls.store | cls.immArith | cls.regArith
                          | cls.ebreak | cls.ecall | cls.mret | cls.csrOp);

endmodule

//--- funcDecode.sv
module funcDecode (
    input  logic [rvDecodePkg::Funct3Width-1:0] funct3,
    input  logic [rvDecodePkg::Funct7Width-1:0] funct7,
    funcIf.source                               fn
);
    import rvDecodePkg::*;

    logic f7Zero;
    logic f7Alt;

    assign f7Zero = funct7 == '0;
    assign f7Alt  = funct7 == Funct7Alt;

    // alu op for both arith forms
    always_comb begin
        fn.regAluOp = AluAdd;  // slt/sltu and bad funct7 land here
        fn.immAluOp = AluAdd;
        case (funct3)
            3'b000: if (f7Alt) fn.regAluOp = AluSub;  // addi never subtracts
            3'b001: begin
                if (f7Zero) begin
                    fn.regAluOp = AluSll;
                    fn.immAluOp = AluSll;
                end
            end
            3'b101: begin
                if (f7Zero) begin
                    fn.regAluOp = AluSrl;
                    fn.immAluOp = AluSrl;
                end else if (f7Alt) begin
                    fn.regAluOp = AluSra;
                    fn.immAluOp = AluSra;
                end
            end
            3'b100: begin
                fn.regAluOp = AluXor;
                fn.immAluOp = AluXor;
            end
            3'b110: begin
                fn.regAluOp = AluOr;
                fn.immAluOp = AluOr;
            end
            3'b111: begin
                fn.regAluOp = AluAnd;
                fn.immAluOp = AluAnd;
            end
            default: ;
        endcase
    end

    // compare and memory candidates
    always_comb begin
        case (funct3)
            3'b001:  fn.branchCmp = CmpNe;
            3'b100:  fn.branchCmp = CmpLt;
            3'b101:  fn.branchCmp = CmpGe;
            3'b110:  fn.branchCmp = CmpLtu;
            3'b111:  fn.branchCmp = CmpGeu;
            default: fn.branchCmp = CmpEq;  // 000 and the two unused codes
        endcase
        fn.isSetForm = funct3[2:1] == 2'b01;  // 010 / 011
        fn.setCmp    = funct3[0] ? CmpLtu : CmpLt;
        case (funct3)
            3'b000:  fn.memMask = 8'h01;
            3'b001:  fn.memMask = 8'h03;
            3'b010:  fn.memMask = 8'h0f;
            default: fn.memMask = '0;
        endcase
        case (funct3)
            3'b001:  fn.memType = MemHalf;
            3'b010:  fn.memType = MemWord;
            3'b100:  fn.memType = MemByteU;
            3'b101:  fn.memType = MemHalfU;
            default: fn.memType = MemByte;
        endcase
    end

endmodule

//--- ctrlCombine.sv
module ctrlCombine (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    output logic                  inReady,
    classIf.sink                  cls,
    funcIf.sink                   fn,
    output logic                  outValid,
    input  logic                  outReady,
    output rvDecodePkg::ctrlWordT ctrl
);
    import rvDecodePkg::*;

    ctrlWordT nextCtrl;
    logic     condSet;   // slt / slti family
    logic     csrrs;
    logic     noWrite;

    assign condSet = (cls.immArith | cls.regArith) & fn.isSetForm;
    assign csrrs   = cls.csrOp & fn.isSetForm & (fn.setCmp == CmpLt);  // funct3 010
    assign noWrite = cls.branch | cls.store | cls.ecall | cls.mret | cls.ebreak | cls.mismatch;

    always_comb begin
        nextCtrl          = '0;
        nextCtrl.memValid = cls.load | cls.store;
        nextCtrl.memWen   = cls.store;
        nextCtrl.memWmask = fn.memMask;  // raw funct3 view, only meaningful with memValid
        nextCtrl.memType  = fn.memType;
        nextCtrl.branch   = cls.branch;
        nextCtrl.jump     = cls.jal | cls.jalr;
        nextCtrl.jalr     = cls.jalr;
        nextCtrl.ecall    = cls.ecall;
        nextCtrl.mret     = cls.mret;
        nextCtrl.writeCsr = cls.csrOp | cls.ecall;
        nextCtrl.stopSim  = cls.ebreak | cls.mismatch;

        if (cls.branch)
            nextCtrl.cmpType = fn.branchCmp;
        else if (condSet)
            nextCtrl.cmpType = fn.setCmp;
        else
            nextCtrl.cmpType = CmpEq;

        if (cls.branch | condSet | csrrs)
            nextCtrl.aluOp = AluSub;  // compare done as subtract
        else if (cls.regArith)
            nextCtrl.aluOp = fn.regAluOp;
        else if (cls.immArith)
            nextCtrl.aluOp = fn.immAluOp;
        else
            nextCtrl.aluOp = AluAdd;  // address / pc math

        if (noWrite)
            nextCtrl.rdSrc = RdNone;  // wins over everything
        else if (cls.load)
            nextCtrl.rdSrc = RdMem;
        else if (cls.jal | cls.jalr)
            nextCtrl.rdSrc = RdSnpc;
        else if (condSet)
            nextCtrl.rdSrc = RdCmp;
        else if (cls.csrOp)
            nextCtrl.rdSrc = RdCsr;
        else
            nextCtrl.rdSrc = RdAlu;

        if (cls.auipc)
            nextCtrl.aluSrc1 = Src1Pc;
        else if (cls.lui)
            nextCtrl.aluSrc1 = Src1Zero;
        else
            nextCtrl.aluSrc1 = Src1Reg;

        if (cls.regArith | cls.branch)
            nextCtrl.aluSrc2 = Src2Reg;
        else if (cls.csrOp)
            nextCtrl.aluSrc2 = Src2Csr;
        else
            nextCtrl.aluSrc2 = Src2Imm;

        if (cls.lui | cls.auipc)
            nextCtrl.instType = TypeU;
        else if (cls.jal)
            nextCtrl.instType = TypeJ;
        else if (cls.jalr | cls.load | cls.immArith)
            nextCtrl.instType = TypeI;
        else if (cls.store)
            nextCtrl.instType = TypeS;
        else if (cls.branch)
            nextCtrl.instType = TypeB;
        else if (cls.regArith)
            nextCtrl.instType = TypeR;
        else
            nextCtrl.instType = TypeN;  // system and illegal
    end

    // one-entry output stage, accepts while draining
    assign inReady = ~outValid | outReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            ctrl     <= '0;
        end else if (inValid && inReady) begin
            outValid <= 1'b1;
            ctrl     <= nextCtrl;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    holdWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(ctrl));

    // classifier groups must not overlap, system sub-codes ride on csrOp
    classOneHot: assert property (@(posedge clk) disable iff (!arstN)
        inValid |-> $onehot0({cls.lui, cls.auipc, cls.jal, cls.jalr, cls.branch, cls.load,
                              cls.store, cls.immArith, cls.regArith, cls.csrOp, cls.mismatch}));

endmodule

//--- instDecoder.sv
module instDecoder (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                inValid,
    output logic                                inReady,
    input  logic [rvDecodePkg::InstWidth-1:0]   inst,
    output logic                                outValid,
    input  logic                                outReady,
    output logic                                memValid,
    output logic [rvDecodePkg::MaskWidth-1:0]   memWmask,
    output logic                                memWen,
    output rvDecodePkg::memTypeE                memType,
    output rvDecodePkg::cmpTypeE                cmpType,
    output logic                                branch,
    output logic                                jump,
    output logic                                jalr,
    output rvDecodePkg::aluOpE                  aluOp,
    output rvDecodePkg::rdSrcE                  rdSrc,
    output rvDecodePkg::aluSrc1E                aluSrc1,
    output rvDecodePkg::aluSrc2E                aluSrc2,
    output rvDecodePkg::instTypeE               instType,
    output logic                                ecall,
    output logic                                mret,
    output logic                                writeCsr,
    output logic                                stopSim
);
    import rvDecodePkg::*;

    ctrlWordT ctrl;

    classIf clsBus ();
    funcIf  fnBus ();

    opClassDecode uClass (
        .opcode  (inst[6:0]),
        .funct3  (inst[14:12]),
        .funct12 (inst[31:20]),  // ecall / ebreak / mret code
        .cls     (clsBus.source)
    );

    funcDecode uFunc (
        .funct3 (inst[14:12]),
        .funct7 (inst[31:25]),
        .fn     (fnBus.source)
    );

    ctrlCombine uCombine (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .cls      (clsBus.sink),
        .fn       (fnBus.sink),
        .outValid (outValid),
        .outReady (outReady),
        .ctrl     (ctrl)
    );

    // registered word out to flat ports
    assign memValid = ctrl.memValid;
    assign memWmask = ctrl.memWmask;
    assign memWen   = ctrl.memWen;
    assign memType  = ctrl.memType;
    assign cmpType  = ctrl.cmpType;
    assign branch   = ctrl.branch;
    assign jump     = ctrl.jump;
    assign jalr     = ctrl.jalr;
    assign aluOp    = ctrl.aluOp;
    assign rdSrc    = ctrl.rdSrc;
    assign aluSrc1  = ctrl.aluSrc1;
    assign aluSrc2  = ctrl.aluSrc2;
    assign instType = ctrl.instType;
    assign ecall    = ctrl.ecall;
    assign mret     = ctrl.mret;
    assign writeCsr = ctrl.writeCsr;
    assign stopSim  = ctrl.stopSim;

endmodule

//--- decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected control word, walked per opcode straight from the ISA encoding
function automatic rvDecodePkg::ctrlWordT decodeModel(
    input logic [rvDecodePkg::InstWidth-1:0] inst
);
    rvDecodePkg::ctrlWordT c;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] f12;
    logic        isReg;
    opc   = inst[6:0];
    f3    = inst[14:12];
    f7    = inst[31:25];
    f12   = inst[31:20];
    isReg = opc[5];  // op vs op-imm
    c     = '0;      // alu add, reg src1, rdSrc alu, cmp eq
    c.aluSrc2  = rvDecodePkg::Src2Imm;
    c.instType = rvDecodePkg::TypeN;
    case (f3)  // size fields track funct3 on every opcode
        3'b000: c.memWmask = 8'h01;
        3'b001: c.memWmask = 8'h03;
        3'b010: c.memWmask = 8'h0f;
        default: c.memWmask = 8'h00;
    endcase
    case (f3)
        3'b001: c.memType = rvDecodePkg::MemHalf;
        3'b010: c.memType = rvDecodePkg::MemWord;
        3'b100: c.memType = rvDecodePkg::MemByteU;
        3'b101: c.memType = rvDecodePkg::MemHalfU;
        default: c.memType = rvDecodePkg::MemByte;
    endcase
    case (opc)
        7'b0110111: begin  // lui
            c.instType = rvDecodePkg::TypeU;
            c.aluSrc1  = rvDecodePkg::Src1Zero;
        end
        7'b0010111: begin  // auipc
            c.instType = rvDecodePkg::TypeU;
            c.aluSrc1  = rvDecodePkg::Src1Pc;
        end
        7'b1101111: begin  // jal
            c.instType = rvDecodePkg::TypeJ;
            c.jump     = 1'b1;
            c.rdSrc    = rvDecodePkg::RdSnpc;
        end
        7'b1100111: begin  // jalr, illegal unless funct3 000
            if (f3 == 3'b000) begin
                c.instType = rvDecodePkg::TypeI;
                c.jump     = 1'b1;
                c.jalr     = 1'b1;
                c.rdSrc    = rvDecodePkg::RdSnpc;
            end else begin
                c.stopSim = 1'b1;
                c.rdSrc   = rvDecodePkg::RdNone;
            end
        end
        7'b1100011: begin  // branch
            c.instType = rvDecodePkg::TypeB;
            c.branch   = 1'b1;
            c.aluSrc2  = rvDecodePkg::Src2Reg;
            c.aluOp    = rvDecodePkg::AluSub;
            c.rdSrc    = rvDecodePkg::RdNone;
            case (f3)
                3'b001: c.cmpType = rvDecodePkg::CmpNe;
                3'b100: c.cmpType = rvDecodePkg::CmpLt;
                3'b101: c.cmpType = rvDecodePkg::CmpGe;
                3'b110: c.cmpType = rvDecodePkg::CmpLtu;
                3'b111: c.cmpType = rvDecodePkg::CmpGeu;
                default: c.cmpType = rvDecodePkg::CmpEq;
            endcase
        end
        7'b0000011: begin  // load
            c.instType = rvDecodePkg::TypeI;
            c.memValid = 1'b1;
            c.rdSrc    = rvDecodePkg::RdMem;
        end
        7'b0100011: begin  // store
            c.instType = rvDecodePkg::TypeS;
            c.memValid = 1'b1;
            c.memWen   = 1'b1;
            c.rdSrc    = rvDecodePkg::RdNone;
        end
        7'b0010011, 7'b0110011: begin  // op-imm / op
            c.instType = isReg ? rvDecodePkg::TypeR : rvDecodePkg::TypeI;
            if (isReg)
                c.aluSrc2 = rvDecodePkg::Src2Reg;
            if (f3 == 3'b010 || f3 == 3'b011) begin
                c.aluOp   = rvDecodePkg::AluSub;
                c.rdSrc   = rvDecodePkg::RdCmp;
                c.cmpType = f3[0] ? rvDecodePkg::CmpLtu : rvDecodePkg::CmpLt;
            end else if (f3 == 3'b000 && isReg && f7 == rvDecodePkg::Funct7Alt) begin
                c.aluOp = rvDecodePkg::AluSub;
            end else if (f3 == 3'b001 && f7 == 7'd0) begin
                c.aluOp = rvDecodePkg::AluSll;
            end else if (f3 == 3'b101 && f7 == 7'd0) begin
                c.aluOp = rvDecodePkg::AluSrl;
            end else if (f3 == 3'b101 && f7 == rvDecodePkg::Funct7Alt) begin
                c.aluOp = rvDecodePkg::AluSra;
            end else if (f3 == 3'b100) begin
                c.aluOp = rvDecodePkg::AluXor;
            end else if (f3 == 3'b110) begin
                c.aluOp = rvDecodePkg::AluOr;
            end else if (f3 == 3'b111) begin
                c.aluOp = rvDecodePkg::AluAnd;
            end
        end
        7'b1110011: begin  // system
            c.writeCsr = 1'b1;
            c.aluSrc2  = rvDecodePkg::Src2Csr;
            c.rdSrc    = rvDecodePkg::RdCsr;
            if (f3 == 3'b010)
                c.aluOp = rvDecodePkg::AluSub;
            if (f3 == 3'b000) begin
                c.ecall   = f12 == 12'h000;
                c.stopSim = f12 == 12'h001;
                c.mret    = f12 == 12'h302;
                if (c.ecall || c.stopSim || c.mret)
                    c.rdSrc = rvDecodePkg::RdNone;
            end
        end
        default: begin  // unknown opcode
            c.stopSim = 1'b1;
            c.rdSrc   = rvDecodePkg::RdNone;
        end
    endcase
    return c;
endfunction

`endif

//--- tbDecoder.sv
module tbDecoder;
    timeunit 1ns;
    timeprecision 100ps;
    import rvDecodePkg::*;
    `include "decodeModel.svh"

    localparam int ClkPeriod      = 40;
    localparam int NumRand        = 300;                // mixed valid / stall traffic
    localparam int NumInst        = NumRand + 60;       // tail is a full-rate burst
    localparam int WatchdogCycles = NumInst * 4 + 100;

    logic clk, arstN, inValid, inReady, outValid, outReady;
    logic [InstWidth-1:0] inst;
    logic memValid, memWen, branch, jump, jalr, ecall, mret, writeCsr, stopSim;
    logic [MaskWidth-1:0] memWmask;
    memTypeE  memType;
    cmpTypeE  cmpType;
    aluOpE    aluOp;
    rdSrcE    rdSrc;
    aluSrc1E  aluSrc1;
    aluSrc2E  aluSrc2;
    instTypeE instType;

    ctrlWordT got;                  // flat ports packed back into one word
    ctrlWordT expQ[$];              // scoreboard, oldest first
    ctrlWordT lastExp;
    ctrlWordT heldWord;
    integer   seed = 32'hacf8;
    int       errCount = 0;
    int       checkCount = 0;
    int       issued = 0;
    int       recvCount = 0;
    logic     burst = 1'b0;
    logic     inFire = 1'b0;        // handshake seen at the last falling edge
    logic     acceptPending = 1'b0;
    logic     holdPending = 1'b0;
    string    testName = "reset";
    // legal majors plus fence and one dead encoding
    logic [6:0] opPool [0:11] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
                                  7'b1100011, 7'b0000011, 7'b0100011, 7'b0010011,
                                  7'b0110011, 7'b1110011, 7'b0001111, 7'b1111111};

    instDecoder dut (.*);

    assign got = {memValid, memWmask, memWen, memType, cmpType, branch, jump, jalr,
                  aluOp, rdSrc, aluSrc1, aluSrc2, instType, ecall, mret, writeCsr, stopSim};

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] randInst();
        logic [31:0] word;
        logic [3:0]  idx;
        logic [1:0]  pick;
        word = $random(seed);
        idx  = 4'($unsigned($random(seed)) % 12);
        pick = 2'($random(seed));
        word[6:0] = opPool[idx];
        if (word[6:0] == OpSystem && pick != 2'd3) begin
            word[14:12] = 3'b000;   // steer toward ecall / ebreak / mret
            word[31:20] = (pick == 2'd0) ? Funct12Ecall
                        : (pick == 2'd1) ? Funct12Ebreak : Funct12Mret;
        end else if ((word[6:0] == OpReg || word[6:0] == OpImm) && pick != 2'd3) begin
            word[31:25] = pick[0] ? Funct7Alt : 7'd0;
        end else if (word[6:0] == OpJalr && pick != 2'd3) begin
            word[14:12] = 3'b000;
        end
        return word;
    endfunction

    task automatic reportMismatch(input string tn, input string field, input int want,
                                  input int have);
        $display("ERR %s %s expected %0d actual %0d at %0t", tn, field, want, have, $time);
        errCount++;
    endtask

    task automatic compareWord(input string tn, input ctrlWordT w, input ctrlWordT g);
        checkCount++;
        if (g.memValid !== w.memValid) reportMismatch(tn, "memValid", w.memValid, g.memValid);
        if (g.memWmask !== w.memWmask)
            reportMismatch(tn, "memWmask", int'(w.memWmask), int'(g.memWmask));
        if (g.memWen !== w.memWen) reportMismatch(tn, "memWen", w.memWen, g.memWen);
        if (g.memType !== w.memType)
            reportMismatch(tn, "memType", int'(w.memType), int'(g.memType));
        if (g.cmpType !== w.cmpType)
            reportMismatch(tn, "cmpType", int'(w.cmpType), int'(g.cmpType));
        if (g.branch !== w.branch) reportMismatch(tn, "branch", w.branch, g.branch);
        if (g.jump !== w.jump) reportMismatch(tn, "jump", w.jump, g.jump);
        if (g.jalr !== w.jalr) reportMismatch(tn, "jalr", w.jalr, g.jalr);
        if (g.aluOp !== w.aluOp) reportMismatch(tn, "aluOp", int'(w.aluOp), int'(g.aluOp));
        if (g.rdSrc !== w.rdSrc) reportMismatch(tn, "rdSrc", int'(w.rdSrc), int'(g.rdSrc));
        if (g.aluSrc1 !== w.aluSrc1)
            reportMismatch(tn, "aluSrc1", int'(w.aluSrc1), int'(g.aluSrc1));
        if (g.aluSrc2 !== w.aluSrc2)
            reportMismatch(tn, "aluSrc2", int'(w.aluSrc2), int'(g.aluSrc2));
        if (g.instType !== w.instType)
            reportMismatch(tn, "instType", int'(w.instType), int'(g.instType));
        if (g.ecall !== w.ecall) reportMismatch(tn, "ecall", w.ecall, g.ecall);
        if (g.mret !== w.mret) reportMismatch(tn, "mret", w.mret, g.mret);
        if (g.writeCsr !== w.writeCsr) reportMismatch(tn, "writeCsr", w.writeCsr, g.writeCsr);
        if (g.stopSim !== w.stopSim) reportMismatch(tn, "stopSim", w.stopSim, g.stopSim);
    endtask

    // sample mid-cycle, everything settled since the +2 ns drive
    always @(negedge clk) begin
        if (arstN) begin
            if (holdPending) begin      // stalled last cycle, word must not move
                checkCount++;
                if (!outValid || got !== heldWord) begin
                    $display("%s: output word changed during a stall at %0t", testName, $time);
                    errCount++;
                end
            end
            if (acceptPending) begin    // one cycle after acceptance
                checkCount++;
                if (!outValid || got !== lastExp) begin
                    $display("ERR %s latency expected %h actual %h valid %b",
                             testName, lastExp, got, outValid);
                    errCount++;
                end
            end
            if (burst && !inReady) begin
                $display("%s: inReady low with outReady high at %0t", testName, $time);
                errCount++;
            end
            if (outValid && outReady) begin
                recvCount++;
                if (expQ.size() == 0) begin
                    $display("%s: output word with none outstanding at %0t", testName, $time);
                    errCount++;
                end else begin
                    compareWord(testName, expQ.pop_front(), got);
                end
            end
            holdPending   = outValid && !outReady;
            heldWord      = got;
            acceptPending = inValid && inReady;
            inFire        = acceptPending;
            if (acceptPending) begin
                lastExp = decodeModel(inst);
                expQ.push_back(lastExp);
            end
        end
    end

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        inValid  = 1'b0;
        inst     = '0;
        outReady = 1'b0;
        repeat (5) @(posedge clk);
        #2 arstN = 1'b1;
        @(negedge clk);
        checkCount++;
        if (outValid !== 1'b0 || got !== '0) begin
            $display("ERR reset expected valid 0 word 0 actual valid %b word %h", outValid, got);
            errCount++;
        end
        while (issued < NumInst || inValid) begin
            @(posedge clk);
            #2;
            if (inFire)
                inValid = 1'b0;
            burst = issued >= NumRand;
            if (burst)
                testName = "burst";
            else
                testName = "random";
            outReady = burst || ($random(seed) % 3 != 0);
            if (!inValid && issued < NumInst && (burst || $random(seed) % 4 != 0)) begin
                inst    = randInst();
                inValid = 1'b1;
                issued++;
            end
        end
        outReady = 1'b1;                // drain what is left
        do begin
            @(posedge clk);
            #2;
        end while (expQ.size() != 0 || outValid);
        checkCount++;
        if (recvCount != NumInst) begin
            $display("received %0d words but sent %0d", recvCount, NumInst);
            errCount++;
        end
        $display("errors %0d of %0d checks", errCount, checkCount);
        if (errCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("timeout, run did not finish within %0d clock cycles", WatchdogCycles);
        $display("errors %0d of %0d checks", errCount, checkCount);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
rvDecodePkg.sv
classIf.sv
funcIf.sv
opClassDecode.sv
funcDecode.sv
ctrlCombine.sv
instDecoder.sv
tbDecoder.sv

//--- runSim.sh
#!/bin/sh
rm -f sim.log \
    && verilator --binary --timing --assert --top-module tbDecoder -f verilog.f -o simDecoder \
    && ./obj_dir/simDecoder | tee sim.log \
    && grep -q "^Simulation passed$" sim.log \
    || { echo "decoder simulation did not pass"; exit 1; }
